// ==== verilog/bpmPkg.sv ====
package bpmPkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int dataWidth      = 32;
    localparam int addrWidth      = 5;
    localparam int regIndexWidth  = addrWidth - 2;
    localparam int heartbeatWidth = 28;
    localparam int markerWidth    = 24;

    // Bit 0 is the software trigger, the rest are event triggers
    localparam int triggerCount   = 7;

    //////////////////////////////////////////////////
    // Register map, word index

    localparam logic [regIndexWidth-1:0] regHeartbeatReload  = 3'd0;
    localparam logic [regIndexWidth-1:0] regFaReload         = 3'd1;
    localparam logic [regIndexWidth-1:0] regSaReload         = 3'd2;
    localparam logic [regIndexWidth-1:0] regSyncStatus       = 3'd3;
    localparam logic [regIndexWidth-1:0] regSoftTrigger      = 3'd4;
    localparam logic [regIndexWidth-1:0] regTriggerTimestamp = 3'd5;
    localparam logic [regIndexWidth-1:0] regInterlock        = 3'd6;
    localparam logic [regIndexWidth-1:0] regBuildDate        = 3'd7;

    //////////////////////////////////////////////////
    // Reset defaults and fixed values

    localparam logic [heartbeatWidth-1:0] defaultHeartbeatReload = 98;
    localparam logic [markerWidth-1:0]    defaultFaReload        = 9;
    localparam logic [markerWidth-1:0]    defaultSaReload        = 49;
    localparam logic [dataWidth-1:0]      buildDate              = 32'h20240501;
    localparam logic [1:0]                axiRespOkay            = 2'b00;

    //////////////////////////////////////////////////
    // Bundles

    typedef struct packed {
        logic [addrWidth-1:0] awaddr;
        logic                 awvalid;
        logic [dataWidth-1:0] wdata;
        logic                 wvalid;
        logic                 bready;
        logic [addrWidth-1:0] araddr;
        logic                 arvalid;
        logic                 rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic                 bvalid;
        logic [1:0]           bresp;
        logic                 arready;
        logic                 rvalid;
        logic [dataWidth-1:0] rdata;
        logic [1:0]           rresp;
    } axiLiteRsp_t;

    typedef struct packed {
        logic [heartbeatWidth-1:0] heartbeatReload;
        logic [markerWidth-1:0]    faReload;
        logic [markerWidth-1:0]    saReload;
    } markerConfig_t;

    // FA flag lands in bit 1, SA flag in bit 0
    typedef struct packed {
        logic faSynced;
        logic saSynced;
    } syncStatus_t;

    typedef struct packed {
        logic [triggerCount-2:0] eventTrig;
        logic                    softTrig;
    } triggerBus_t;

endpackage

// ==== verilog/heartbeatGenerator.sv ====
`timescale 1ns/1ns

module heartbeatGenerator (
    input  logic                              sysClk,
    input  logic                              reset,
    input  logic [bpmPkg::heartbeatWidth-1:0] heartbeatReload,
    output logic                              heartbeat
);
    import bpmPkg::*;

    // Extra top bit flags the underflow
    logic [heartbeatWidth:0] counter;

    assign heartbeat = counter[heartbeatWidth];

    // Count down to zero, one more cycle to underflow, then reload
    always_ff @(posedge sysClk) begin
        if (reset || heartbeat) begin
            counter <= {1'b0, heartbeatReload};
        end else begin
            counter <= counter - 1'b1;
        end
    end

endmodule

// ==== verilog/markerDivider.sv ====
`timescale 1ns/1ns

module markerDivider (
    input  logic                           sysClk,
    input  logic                           reset,
    input  logic [bpmPkg::markerWidth-1:0] reload,
    input  logic                           heartbeat,
    output logic                           marker,
    output logic                           synced
);
    import bpmPkg::*;

    logic [markerWidth-1:0] counter;

    assign marker = (counter == '0);

    //////////////////////////////////////////////////
    // Divider

    // Heartbeat re-phases the count
    always_ff @(posedge sysClk) begin
        if (reset) begin
            counter <= reload;
        end else if (heartbeat || marker) begin
            counter <= reload;
        end else begin
            counter <= counter - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Sync check

    // In step when the marker falls on the heartbeat itself
    always_ff @(posedge sysClk) begin
        if (reset) begin
            synced <= 1'b0;
        end else if (heartbeat) begin
            synced <= marker;
        end
    end

endmodule

// ==== verilog/triggerCapture.sv ====
`timescale 1ns/1ns

module triggerCapture (
    input  logic                            sysClk,
    input  logic                            reset,
    input  logic [bpmPkg::triggerCount-2:0] eventTriggers,
    input  logic                            softTrigger,
    input  logic                            heartbeat,
    output bpmPkg::triggerBus_t             triggerStrobes,
    output logic [bpmPkg::dataWidth-1:0]    triggerTimestamp
);
    import bpmPkg::*;

    triggerBus_t          triggerInputs;
    triggerBus_t          syncMeta;
    triggerBus_t          syncStage;
    triggerBus_t          syncDelayed;
    logic [dataWidth-1:0] tickCount;
    logic [dataWidth-1:0] ticks;

    // Software trigger rides in bit 0
    assign triggerInputs = {eventTriggers, softTrigger};

    //////////////////////////////////////////////////
    // Synchronizer and edge detect

    always_ff @(posedge sysClk) begin
        if (reset) begin
            syncMeta       <= '0;
            syncStage      <= '0;
            syncDelayed    <= '0;
            triggerStrobes <= '0;
        end else begin
            syncMeta       <= triggerInputs;
            syncStage      <= syncMeta;
            syncDelayed    <= syncStage;
            triggerStrobes <= syncStage & ~syncDelayed;
        end
    end

    //////////////////////////////////////////////////
    // Timestamp

    // Zero in the heartbeat cycle itself
    assign ticks = heartbeat ? '0 : tickCount;

    always_ff @(posedge sysClk) begin
        if (reset) begin
            tickCount        <= '0;
            triggerTimestamp <= '0;
        end else begin
            if (heartbeat) begin
                tickCount <= dataWidth'(1);
            end else begin
                tickCount <= tickCount + dataWidth'(1);
            end
            if (|triggerStrobes) begin
                triggerTimestamp <= ticks;
            end
        end
    end

endmodule

// ==== verilog/bpmRegisterBank.sv ====
`timescale 1ns/1ns

module bpmRegisterBank (
    input  logic                         sysClk,
    input  logic                         reset,
    input  bpmPkg::axiLiteReq_t          axiReq,
    output bpmPkg::axiLiteRsp_t          axiRsp,
    output bpmPkg::markerConfig_t        markerConfig,
    output logic                         softTrigger,
    output logic                         relayControl,
    input  bpmPkg::syncStatus_t          syncStatus,
    input  logic [bpmPkg::dataWidth-1:0] triggerTimestamp,
    input  logic                         interlockResetButton
);
    import bpmPkg::*;

    logic                     writeAccept;
    logic                     readAccept;
    logic [regIndexWidth-1:0] writeIndex;
    logic [regIndexWidth-1:0] readIndex;
    logic                     bvalid;
    logic                     rvalid;
    logic [dataWidth-1:0]     rdata;
    logic [dataWidth-1:0]     readData;
    logic                     buttonMeta;
    logic                     buttonSync;

    //////////////////////////////////////////////////
    // Handshake

    // No new request while a response of the same kind is still held
    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bvalid;
    assign readAccept  = axiReq.arvalid && !rvalid;

    assign writeIndex = axiReq.awaddr[addrWidth-1:2];
    assign readIndex  = axiReq.araddr[addrWidth-1:2];

    assign axiRsp.awready = writeAccept;
    assign axiRsp.wready  = writeAccept;
    assign axiRsp.bvalid  = bvalid;
    assign axiRsp.bresp   = axiRespOkay;
    assign axiRsp.arready = readAccept;
    assign axiRsp.rvalid  = rvalid;
    assign axiRsp.rdata   = rdata;
    assign axiRsp.rresp   = axiRespOkay;

    always_ff @(posedge sysClk) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (writeAccept) begin
                bvalid <= 1'b1;
            end else if (axiReq.bready) begin
                bvalid <= 1'b0;
            end
            if (readAccept) begin
                rvalid <= 1'b1;
            end else if (axiReq.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data holds until the master takes it
    always_ff @(posedge sysClk) begin
        if (readAccept) begin
            rdata <= readData;
        end
    end

    //////////////////////////////////////////////////
    // Configuration registers

    always_ff @(posedge sysClk) begin
        if (reset) begin
            markerConfig.heartbeatReload <= defaultHeartbeatReload;
            markerConfig.faReload        <= defaultFaReload;
            markerConfig.saReload        <= defaultSaReload;
            relayControl                 <= 1'b0;
            softTrigger                  <= 1'b0;
        end else begin
            // One-cycle pulse, data value ignored
            softTrigger <= writeAccept && (writeIndex == regSoftTrigger);
            if (writeAccept) begin
                case (writeIndex)
                    regHeartbeatReload:
                        markerConfig.heartbeatReload <= axiReq.wdata[heartbeatWidth-1:0];
                    regFaReload:
                        markerConfig.faReload <= axiReq.wdata[markerWidth-1:0];
                    regSaReload:
                        markerConfig.saReload <= axiReq.wdata[markerWidth-1:0];
                    regInterlock:
                        relayControl <= axiReq.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // Interlock reset button is asynchronous
    always_ff @(posedge sysClk) begin
        buttonMeta <= interlockResetButton;
        buttonSync <= buttonMeta;
    end

    //////////////////////////////////////////////////
    // Readback

    always_comb begin
        case (readIndex)
            regHeartbeatReload:  readData = dataWidth'(markerConfig.heartbeatReload);
            regFaReload:         readData = dataWidth'(markerConfig.faReload);
            regSaReload:         readData = dataWidth'(markerConfig.saReload);
            regSyncStatus:       readData = dataWidth'(syncStatus);
            regTriggerTimestamp: readData = triggerTimestamp;
            regInterlock:        readData = dataWidth'({buttonSync, relayControl});
            regBuildDate:        readData = buildDate;
            default:             readData = '0;
        endcase
    end

endmodule

// ==== verilog/bpmTop.sv ====
`timescale 1ns/1ns

module bpmTop (
    input  logic                           sysClk,
    input  logic                           reset,
    input  bpmPkg::axiLiteReq_t            axiReq,
    output bpmPkg::axiLiteRsp_t            axiRsp,
    input  logic [bpmPkg::triggerCount-2:0] eventTriggers,
    input  logic                           interlockResetButton,
    output logic                           heartbeat,
    output logic                           faMarker,
    output logic                           saMarker,
    output logic                           relayControl,
    output bpmPkg::triggerBus_t            triggerStrobes
);
    import bpmPkg::*;

    markerConfig_t        markerConfig;
    syncStatus_t          syncStatus;
    logic                 softTrigger;
    logic [dataWidth-1:0] triggerTimestamp;

    //////////////////////////////////////////////////
    // Register bank

    bpmRegisterBank registerBank (
        .sysClk               (sysClk),
        .reset                (reset),
        .axiReq               (axiReq),
        .axiRsp               (axiRsp),
        .markerConfig         (markerConfig),
        .softTrigger          (softTrigger),
        .relayControl         (relayControl),
        .syncStatus           (syncStatus),
        .triggerTimestamp     (triggerTimestamp),
        .interlockResetButton (interlockResetButton)
    );

    //////////////////////////////////////////////////
    // Timing core

    heartbeatGenerator heartbeatGen (
        .sysClk          (sysClk),
        .reset           (reset),
        .heartbeatReload (markerConfig.heartbeatReload),
        .heartbeat       (heartbeat)
    );

    markerDivider faDivider (
        .sysClk    (sysClk),
        .reset     (reset),
        .reload    (markerConfig.faReload),
        .heartbeat (heartbeat),
        .marker    (faMarker),
        .synced    (syncStatus.faSynced)
    );

    markerDivider saDivider (
        .sysClk    (sysClk),
        .reset     (reset),
        .reload    (markerConfig.saReload),
        .heartbeat (heartbeat),
        .marker    (saMarker),
        .synced    (syncStatus.saSynced)
    );

    triggerCapture capture (
        .sysClk           (sysClk),
        .reset            (reset),
        .eventTriggers    (eventTriggers),
        .softTrigger      (softTrigger),
        .heartbeat        (heartbeat),
        .triggerStrobes   (triggerStrobes),
        .triggerTimestamp (triggerTimestamp)
    );

endmodule

// ==== test/bpmChecker.sv ====
`timescale 1ns/1ns

module bpmChecker (
    input logic                            sysClk,
    input logic                            reset,
    input bpmPkg::axiLiteReq_t             axiReq,
    input bpmPkg::axiLiteRsp_t             axiRsp,
    input logic [bpmPkg::triggerCount-2:0] eventTriggers,
    input logic                            interlockResetButton,
    input logic                            heartbeat,
    input logic                            faMarker,
    input logic                            saMarker,
    input logic                            relayControl,
    input bpmPkg::triggerBus_t             triggerStrobes
);
    import bpmPkg::*;

    int          errorCount = 0;
    int          checkCount = 0;
    int unsigned cycle = 0;
    int unsigned lastHeartbeat;
    int unsigned markerLast [2];
    logic        markerBroken [2];
    int          stableHeartbeat;
    int          stableMarker [2];
    logic        heartbeatSeen;
    logic [31:0] reloadModel [3];
    logic        relayModel;
    logic [31:0] timestampModel;
    logic        softPending;
    logic [6:0]  prevInputs;
    logic [6:0]  strobePipe [3];
    logic        wasReset;
    logic        readPending;
    logic        readSkip;
    logic [31:0] readExpected;

    //////////////////////////////////////////////////
    // Reference functions

    function automatic logic [31:0] expectedPeriod(input logic [31:0] reload);
        return reload + 32'd2;
    endfunction

    function automatic logic expectedSynced(input logic [31:0] hbReload,
                                            input logic [31:0] markerReload);
        return ((hbReload + 32'd2) % (markerReload + 32'd1)) == 32'd0;
    endfunction

    function automatic logic [31:0] expectedTimestamp(input int unsigned strobeCycle,
                                                      input int unsigned heartbeatCycle);
        return strobeCycle - heartbeatCycle;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic protocolError(input string message);
        errorCount++;
        $display("Bus error at %0t ns: %s", $time, message);
    endtask

    //////////////////////////////////////////////////
    // Compare process

    always @(posedge sysClk) begin
        logic [6:0] inputs;
        logic [6:0] rise;
        logic       marker;
        cycle++;
        if (reset) begin
            reloadModel[0]  = 32'(defaultHeartbeatReload);
            reloadModel[1]  = 32'(defaultFaReload);
            reloadModel[2]  = 32'(defaultSaReload);
            relayModel      = 1'b0;
            timestampModel  = '0;
            softPending     = 1'b0;
            prevInputs      = '0;
            strobePipe      = '{default: '0};
            stableHeartbeat = 0;
            stableMarker    = '{0, 0};
            markerBroken    = '{1'b1, 1'b1};
            heartbeatSeen   = 1'b0;
            readPending     = 1'b0;
            lastHeartbeat   = cycle + 1;
            wasReset        = 1'b1;
        end else begin
            if (wasReset) begin
                compareValue("outputs after reset", 32'({heartbeat, faMarker, saMarker,
                    relayControl, triggerStrobes, axiRsp.awready, axiRsp.wready,
                    axiRsp.bvalid, axiRsp.arready, axiRsp.rvalid}), '0);
            end
            wasReset = 1'b0;

            // Handshake rules
            if (axiRsp.awready && axiRsp.bvalid) begin
                protocolError("write accepted while a write response was pending");
            end
            if (axiRsp.arready && axiRsp.rvalid) begin
                protocolError("read accepted while read data was pending");
            end
            if (axiRsp.awready != axiRsp.wready) begin
                protocolError("awready and wready differ");
            end
            if (axiRsp.bvalid && axiReq.bready) begin
                compareValue("bresp", 32'(axiRsp.bresp), '0);
            end

            // Returned read data and the next read's expected value
            if (axiRsp.rvalid && axiReq.rready) begin
                if (!readPending) begin
                    protocolError("read data returned without a request");
                end else if (!readSkip) begin
                    compareValue("rdata", axiRsp.rdata, readExpected);
                end
                compareValue("rresp", 32'(axiRsp.rresp), '0);
                readPending = 1'b0;
            end
            if (axiRsp.arready && axiReq.arvalid) begin
                readSkip    = 1'b0;
                readPending = 1'b1;
                case (axiReq.araddr[addrWidth-1:2])
                    regHeartbeatReload:  readExpected = reloadModel[0];
                    regFaReload:         readExpected = reloadModel[1];
                    regSaReload:         readExpected = reloadModel[2];
                    regSyncStatus: begin
                        // Both flags stay low until the first heartbeat
                        if (!heartbeatSeen) begin
                            readExpected = '0;
                        end else begin
                            readExpected = {30'd0,
                                            expectedSynced(reloadModel[0], reloadModel[1]),
                                            expectedSynced(reloadModel[0], reloadModel[2])};
                            readSkip = (stableMarker[0] < 2) || (stableMarker[1] < 2);
                        end
                    end
                    regTriggerTimestamp: readExpected = timestampModel;
                    regInterlock:  readExpected = {30'd0, interlockResetButton, relayModel};
                    regBuildDate:  readExpected = buildDate;
                    default:       readExpected = '0;
                endcase
            end

            // Heartbeat and marker spacing once the reloads have settled
            if (heartbeat) begin
                if (stableHeartbeat >= 2) begin
                    compareValue("heartbeat period", cycle - lastHeartbeat,
                                 expectedPeriod(reloadModel[0]));
                end
                lastHeartbeat = cycle;
                heartbeatSeen = 1'b1;
                stableHeartbeat++;
                stableMarker[0]++;
                stableMarker[1]++;
            end
            for (int i = 0; i < 2; i++) begin
                marker = (i == 0) ? faMarker : saMarker;
                if (marker) begin
                    if (!markerBroken[i] && stableMarker[i] >= 2) begin
                        compareValue(i == 0 ? "faMarker period" : "saMarker period",
                                     cycle - markerLast[i], reloadModel[i+1] + 32'd1);
                    end
                    markerLast[i]   = cycle;
                    markerBroken[i] = 1'b0;
                end else if (heartbeat) begin
                    markerBroken[i] = 1'b1;
                end
            end

            // Strobe three edges after the rising sample
            inputs     = {eventTriggers, softPending};
            rise       = inputs & ~prevInputs;
            prevInputs = inputs;
            compareValue("triggerStrobes", 32'(triggerStrobes), 32'(strobePipe[2]));
            if (|strobePipe[2]) begin
                timestampModel = expectedTimestamp(cycle, lastHeartbeat);
            end
            strobePipe[2] = strobePipe[1];
            strobePipe[1] = strobePipe[0];
            strobePipe[0] = rise;
            compareValue("relayControl", 32'(relayControl), 32'(relayModel));

            // Register model follows accepted writes
            softPending = 1'b0;
            if (axiRsp.awready && axiReq.awvalid && axiReq.wvalid) begin
                case (axiReq.awaddr[addrWidth-1:2])
                    regHeartbeatReload: begin
                        reloadModel[0]  = axiReq.wdata & ((32'd1 << heartbeatWidth) - 32'd1);
                        stableHeartbeat = 0;
                        stableMarker    = '{0, 0};
                    end
                    regFaReload: begin
                        reloadModel[1]  = axiReq.wdata & ((32'd1 << markerWidth) - 32'd1);
                        stableMarker[0] = 0;
                    end
                    regSaReload: begin
                        reloadModel[2]  = axiReq.wdata & ((32'd1 << markerWidth) - 32'd1);
                        stableMarker[1] = 0;
                    end
                    regSoftTrigger: softPending = 1'b1;
                    regInterlock:   relayModel = axiReq.wdata[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== test/bpmTopTb.sv ====
`timescale 1ns/1ns

module bpmTopTb;
    import bpmPkg::*;

    localparam int clockPeriod    = 4;
    localparam int seedValue      = 27735;
    localparam int resetCycles    = 5;
    localparam int handshakeLimit = 50;

    // Cycle budgets of the six tests
    localparam int resetTestCycles     = 400;
    localparam int heartbeatTestCycles = 500;
    localparam int markerTestCycles    = 600;
    localparam int eventTestCycles     = 400;
    localparam int softTestCycles      = 400;
    localparam int interlockTestCycles = 300;
    localparam int watchdogCycles = resetTestCycles + heartbeatTestCycles + markerTestCycles
                                  + eventTestCycles + softTestCycles + interlockTestCycles + 1000;

    logic        sysClk;
    logic        reset;
    axiLiteReq_t axiReq;
    axiLiteRsp_t axiRsp;
    logic [5:0]  eventTriggers;
    logic        interlockResetButton;
    logic        heartbeat;
    logic        faMarker;
    logic        saMarker;
    logic        relayControl;
    triggerBus_t triggerStrobes;
    int          seed;
    int          tbErrors;
    int          errorMark;

    bpmTop dut (
        .sysClk               (sysClk),
        .reset                (reset),
        .axiReq               (axiReq),
        .axiRsp               (axiRsp),
        .eventTriggers        (eventTriggers),
        .interlockResetButton (interlockResetButton),
        .heartbeat            (heartbeat),
        .faMarker             (faMarker),
        .saMarker             (saMarker),
        .relayControl         (relayControl),
        .triggerStrobes       (triggerStrobes)
    );

    bpmChecker scoreboard (
        .sysClk               (sysClk),
        .reset                (reset),
        .axiReq               (axiReq),
        .axiRsp               (axiRsp),
        .eventTriggers        (eventTriggers),
        .interlockResetButton (interlockResetButton),
        .heartbeat            (heartbeat),
        .faMarker             (faMarker),
        .saMarker             (saMarker),
        .relayControl         (relayControl),
        .triggerStrobes       (triggerStrobes)
    );

    initial begin
        sysClk = 1'b0;
        forever #(clockPeriod / 2) sysClk = ~sysClk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge sysClk);
        $display("Run stopped by the watchdog after %0d cycles", watchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Bus and wait tasks

    task automatic waitCycles(input int count);
        repeat (count) @(posedge sysClk);
    endtask

    task automatic waitHeartbeats(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < count * 300) begin
            @(posedge sysClk);
            cycles++;
            if (heartbeat) seen++;
        end
        if (seen < count) begin
            tbErrors++;
            $display("Heartbeat stopped after %0d of %0d pulses", seen, count);
        end
    endtask

    task automatic waitWriteAccept();
        int cycles;
        cycles = 0;
        do begin
            @(posedge sysClk);
            cycles++;
        end while (!axiRsp.awready && cycles < handshakeLimit);
        if (!axiRsp.awready) begin
            tbErrors++;
            $display("Write to 0x%0h was never accepted", axiReq.awaddr);
        end
        #1;
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
    endtask

    task automatic waitWriteResponse();
        int cycles;
        cycles = 0;
        do begin
            @(posedge sysClk);
            cycles++;
        end while (!(axiRsp.bvalid && axiReq.bready) && cycles < handshakeLimit);
        if (!axiRsp.bvalid) begin
            tbErrors++;
            $display("Write response never arrived");
        end
    endtask

    task automatic startWrite(input logic [2:0] index, input logic [31:0] data);
        @(posedge sysClk);
        #1;
        axiReq.awaddr  = {index, 2'b00};
        axiReq.awvalid = 1'b1;
        axiReq.wdata   = data;
        axiReq.wvalid  = 1'b1;
    endtask

    task automatic axiWrite(input logic [2:0] index, input logic [31:0] data);
        startWrite(index, data);
        waitWriteAccept();
        waitWriteResponse();
    endtask

    task automatic axiRead(input logic [2:0] index);
        int cycles;
        @(posedge sysClk);
        #1;
        axiReq.araddr  = {index, 2'b00};
        axiReq.arvalid = 1'b1;
        cycles = 0;
        do begin
            @(posedge sysClk);
            cycles++;
        end while (!axiRsp.arready && cycles < handshakeLimit);
        #1;
        axiReq.arvalid = 1'b0;
        cycles = 0;
        do begin
            @(posedge sysClk);
            cycles++;
        end while (!(axiRsp.rvalid && axiReq.rready) && cycles < handshakeLimit);
        if (!axiRsp.rvalid) begin
            tbErrors++;
            $display("Read of 0x%0h never returned data", {index, 2'b00});
        end
    endtask

    task automatic finishTest(input int number, input string name);
        int total;
        // Step past the edge so its compares are counted
        #1;
        total = scoreboard.errorCount + tbErrors;
        $display("Test %0d %s: %0d errors", number, name, total - errorMark);
        errorMark = total;
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        int reloadValue;
        int bitIndex;
        int total;
        seed                 = seedValue;
        tbErrors             = 0;
        errorMark            = 0;
        reset                = 1'b1;
        axiReq               = '0;
        axiReq.bready        = 1'b1;
        axiReq.rready        = 1'b1;
        eventTriggers        = '0;
        interlockResetButton = 1'b0;
        repeat (resetCycles) @(posedge sysClk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 8; i++) axiRead(3'(i));
        // Right after a heartbeat, so a random reload never gets loaded
        waitHeartbeats(1);
        for (int i = 0; i < 3; i++) begin
            axiWrite(3'(i), $random(seed));
            axiRead(3'(i));
        end
        axiWrite(regHeartbeatReload, 32'(defaultHeartbeatReload));
        axiWrite(regFaReload, 32'(defaultFaReload));
        axiWrite(regSaReload, 32'(defaultSaReload));
        finishTest(1, "reset state and readback");

        reloadValue = 20 + ($random(seed) & 31);
        axiWrite(regHeartbeatReload, 32'(reloadValue));
        waitHeartbeats(5);
        finishTest(2, "heartbeat period");

        // FA divides a period of 24 and SA does not, then the reverse
        axiWrite(regHeartbeatReload, 32'd22);
        axiWrite(regFaReload, 32'd5);
        axiWrite(regSaReload, 32'd6);
        waitHeartbeats(3);
        axiRead(regSyncStatus);
        axiWrite(regFaReload, 32'd6);
        axiWrite(regSaReload, 32'd7);
        waitHeartbeats(3);
        axiRead(regSyncStatus);
        finishTest(3, "marker period and sync");

        repeat (8) begin
            bitIndex = ($random(seed) & 32'h7fff_ffff) % 6;
            @(posedge sysClk);
            #1;
            eventTriggers[bitIndex] = 1'b1;
            waitCycles(12);
            #1;
            eventTriggers[bitIndex] = 1'b0;
            waitCycles(8);
        end
        finishTest(4, "event trigger strobes");

        repeat (2) begin
            waitHeartbeats(1);
            waitCycles(3 + ($random(seed) & 7));
            axiWrite(regSoftTrigger, 32'd0);
            waitCycles(8);
            axiRead(regTriggerTimestamp);
        end
        finishTest(5, "software trigger and timestamp");

        @(posedge sysClk);
        #1;
        interlockResetButton = 1'b1;
        axiWrite(regInterlock, 32'd1);
        waitCycles(3);
        axiRead(regInterlock);
        @(posedge sysClk);
        #1;
        interlockResetButton = 1'b0;
        axiReq.bready        = 1'b0;
        startWrite(regInterlock, 32'd0);
        waitWriteAccept();
        // Second write waits behind the held response
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = 32'd1;
        repeat (6) begin
            @(posedge sysClk);
            if (axiRsp.awready) begin
                tbErrors++;
                $display("Second write was accepted while the first response was held");
            end
        end
        #1;
        axiReq.bready = 1'b1;
        waitWriteAccept();
        waitWriteResponse();
        waitCycles(2);
        axiRead(regInterlock);
        finishTest(6, "interlock and back-pressure");

        total = scoreboard.errorCount + tbErrors;
        $display("Summary: %0d checks, %0d errors", scoreboard.checkCount, total);
        if (total == 0 && scoreboard.checkCount > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/bpmPkg.sv
verilog/heartbeatGenerator.sv
verilog/markerDivider.sv
verilog/triggerCapture.sv
verilog/bpmRegisterBank.sv
verilog/bpmTop.sv
test/bpmChecker.sv
test/bpmTopTb.sv

// ==== Makefile ====
# Verilator build and run for the BPM timing core

VERILATOR ?= verilator
TOP       ?= bpmTopTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
